// ==== hw/kws_settings.svh ====
// Array sizes, memory depths and position-row reset patterns shared by the
// keyword-spotting data distributor and its testbench
`ifndef KWS_SETTINGS_SVH
`define KWS_SETTINGS_SVH

// Feature bank geometry, the bank holds 2*N_MEL rows
`define KWS_N_MEL        32
`define KWS_N_FRAME      64
`define KWS_N_PATCH      58

// PE array
`define KWS_N_PE_COL     5
`define KWS_N_ELEMENT    4

// Decoder bank depths
`define KWS_BLOCK_DEPTH  2048
`define KWS_CCL_DEPTH    4096

// Position windows, format {win 57 .. win 0}
`define KWS_POS_INIT0    58'h3FF_FFFF_FFFF_FFFE
`define KWS_POS_INIT1    58'h3FF_FFFF_FFFF_FFFC

`endif

// ==== hw/kws_pkg.sv ====
// Shared types of the data distributor: column-select encoding and the
// per-column decoder and PE-lane bundles
`include "kws_settings.svh"

package kws_pkg;

    // Literal source of a PE column, SEL_SHIFTk takes row bits k-1 .. k+56
    typedef enum logic [2:0] {
        SEL_POSITION = 3'd0,
        SEL_SHIFT1   = 3'd1,
        SEL_SHIFT2   = 3'd2,
        SEL_SHIFT3   = 3'd3,
        SEL_SHIFT4   = 3'd4,
        SEL_SHIFT5   = 3'd5,
        SEL_SHIFT6   = 3'd6,
        SEL_SHIFT7   = 3'd7
    } col_sel_e;

    typedef struct packed {
        logic     clause;
        logic     invert;
        col_sel_e col_sel;
    } clause_code_t;

    // Column-stage signals from the decoder, one entry per PE column
    typedef struct packed {
        logic                                 row_valid;
        logic                                 row_spad_index;
        logic                                 col_valid;
        logic                                 col_ready;
        clause_code_t                         clause_code;
        logic [1:0]                           stage_code;
        logic [$clog2(`KWS_CCL_DEPTH)-1:0]    ccl_raddr;
    } col_stage_t;

    typedef struct packed {
        logic [1:0]                   stage_code;
        logic                         ena;
        logic                         clause_sel;
        logic                         inv_en;
        logic [2*`KWS_N_ELEMENT-1:0]  flush_flags;
        logic [`KWS_N_PATCH-1:0]      literal;
    } pe_lane_t;

endpackage

// ==== hw/feature_fetch.sv ====
// Feature fetch for the data distributor
// Issues two feature-bank reads per block handshake, fills a double-buffered
// row scratchpad and keeps the two sliding position-window rows
`timescale 1ns/1ps
`include "kws_settings.svh"

module feature_fetch (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  decode_en,
    input  logic                                  block_ready,
    input  logic [`KWS_N_FRAME-1:0]               feature_rdata,
    input  logic                                  clause_flush,
    output logic                                  feature_ren,
    output logic [$clog2(2*`KWS_N_MEL)-1:0]       feature_rptr,
    output logic [`KWS_N_FRAME-1:0]               row_lo,
    output logic [`KWS_N_FRAME-1:0]               row_hi,
    output logic [`KWS_N_PATCH-1:0]               pos_lo,
    output logic [`KWS_N_PATCH-1:0]               pos_hi,
    output logic                                  row_ptr_zero
);

    localparam int PTR_W = $clog2(2 * `KWS_N_MEL);

    logic                     handshake;
    logic                     rd_phase;
    logic [PTR_W-1:0]         rd_ptr;
    logic                     rd_pending;
    logic [1:0]               wr_slot;
    logic                     rd_sel;
    logic                     swap_d1;
    logic                     swap_d2;
    logic [`KWS_N_FRAME-1:0]  spad [4];

    assign handshake    = decode_en && block_ready;
    assign row_ptr_zero = (rd_ptr == '0);

    // ------------------------------------------------------------------------
    // Feature bank reads
    // ------------------------------------------------------------------------

    // Second read of the pair always follows the first
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_phase <= 1'b0;
            rd_ptr   <= '0;
        end else if (handshake && !rd_phase) begin
            rd_phase <= 1'b1;
            rd_ptr   <= rd_ptr + 1'b1;
        end else if (rd_phase) begin
            rd_phase <= 1'b0;
            rd_ptr   <= rd_ptr + 1'b1;
        end
    end

    assign feature_ren  = handshake || rd_phase;
    assign feature_rptr = rd_ptr;

    // Bank data is valid one cycle after the strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= feature_ren;
        end
    end

    // ------------------------------------------------------------------------
    // Row scratchpad, slot = {pair, lo/hi}
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_slot <= 2'd0;
        end else if (rd_pending) begin
            wr_slot <= wr_slot + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pending) begin
            spad[wr_slot] <= feature_rdata;
        end
    end

    // Handshake past the first row of a clause swaps pairs two cycles on
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            swap_d1 <= 1'b0;
            swap_d2 <= 1'b0;
        end else begin
            swap_d1 <= handshake && !row_ptr_zero;
            swap_d2 <= swap_d1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_sel <= 1'b0;
        end else if (clause_flush) begin
            rd_sel <= 1'b0;
        end else if (swap_d2) begin
            rd_sel <= ~rd_sel;
        end
    end

    assign row_lo = spad[{rd_sel, 1'b0}];
    assign row_hi = spad[{rd_sel, 1'b1}];

    // ------------------------------------------------------------------------
    // Position windows
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos_lo <= `KWS_POS_INIT0;
            pos_hi <= `KWS_POS_INIT1;
        end else if (clause_flush) begin
            pos_lo <= `KWS_POS_INIT0;
            pos_hi <= `KWS_POS_INIT1;
        end else if (swap_d2) begin
            pos_lo <= pos_lo << 2;
            pos_hi <= pos_hi << 2;
        end
    end

    // Each handshake yields exactly a two-cycle read burst
    a_ren_burst: assert property (@(posedge clk) disable iff (!rst_n)
        feature_ren ##1 feature_ren |=> !feature_ren)
        else $error("feature_ren high for three cycles in a row");

endmodule

// ==== hw/pe_column_lane.sv ====
// PE column lane
// Aligns the row scratchpad index with the column stage, picks the literal
// window for the column and keeps its flush-flag register
`timescale 1ns/1ps
`include "kws_settings.svh"

module pe_column_lane import kws_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  col_stage_t                col_stage,
    input  logic [`KWS_N_FRAME-1:0]   row_lo,
    input  logic [`KWS_N_FRAME-1:0]   row_hi,
    input  logic [`KWS_N_PATCH-1:0]   pos_lo,
    input  logic [`KWS_N_PATCH-1:0]   pos_hi,
    input  logic                      clause_flush,
    output pe_lane_t                  lane
);

    logic                             spad_idx;
    logic [`KWS_N_FRAME-1:0]          row_data;
    logic [`KWS_N_PATCH-1:0]          pos_data;
    logic [2:0]                       shift;
    logic [`KWS_N_PATCH-1:0]          literal;
    logic [2*`KWS_N_ELEMENT-1:0]      flush_flags;

    // Row-stage index lines up with the column stage one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spad_idx <= 1'b0;
        end else if (col_stage.row_valid && col_stage.col_ready) begin
            spad_idx <= col_stage.row_spad_index;
        end
    end

    assign row_data = spad_idx ? row_hi : row_lo;
    assign pos_data = spad_idx ? pos_hi : pos_lo;

    // Literal window
    assign shift = col_stage.clause_code.col_sel - 3'd1;

    always_comb begin
        if (col_stage.clause_code.col_sel == SEL_POSITION) begin
            literal = pos_data;
        end else begin
            literal = row_data[shift +: `KWS_N_PATCH];
        end
    end

    // One flag per {stage, clause}, cleared as the PE consumes it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flush_flags <= '1;
        end else if (clause_flush) begin
            flush_flags <= '1;
        end else if (col_stage.col_valid) begin
            flush_flags[{col_stage.stage_code, col_stage.clause_code.clause}] <= 1'b0;
        end
    end

    assign lane.stage_code  = col_stage.stage_code;
    assign lane.ena         = col_stage.col_valid;
    assign lane.clause_sel  = col_stage.clause_code.clause;
    assign lane.inv_en      = col_stage.clause_code.invert;
    assign lane.flush_flags = flush_flags;
    assign lane.literal     = literal;

    a_flush_sets: assert property (@(posedge clk) disable iff (!rst_n)
        clause_flush |=> (lane.flush_flags == '1))
        else $error("flush_flags not all ones after clause_flush");

endmodule

// ==== hw/clause_tracker.sv ====
// Clause tracker
// Spots a clause start on the block stage and the last clause on the column
// stage, and turns both into the clause-boundary flush and summation enable
`timescale 1ns/1ps
`include "kws_settings.svh"

module clause_tracker import kws_pkg::*; (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  decode_en,
    input  logic                                  block_ready,
    input  logic                                  row_ptr_zero,
    input  logic [$clog2(`KWS_BLOCK_DEPTH)-1:0]   block_raddr,
    input  col_stage_t                            col_stage [`KWS_N_PE_COL],
    output logic                                  clause_flush,
    output logic                                  summation_ena
);

    logic start_d1;
    logic start_d2;
    logic start_d3;
    logic any_valid;
    logic any_valid_d1;
    logic all_addr_zero;
    logic last_clause;

    // New clause when the block stage restarts at row zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_d1 <= 1'b0;
            start_d2 <= 1'b0;
            start_d3 <= 1'b0;
        end else begin
            start_d1 <= decode_en && block_ready && row_ptr_zero && (block_raddr != '0);
            start_d2 <= start_d1;
            start_d3 <= start_d2;
        end
    end

    always_comb begin
        any_valid     = 1'b0;
        all_addr_zero = 1'b1;
        for (int c = 0; c < `KWS_N_PE_COL; c++) begin
            any_valid     = any_valid | col_stage[c].col_valid;
            all_addr_zero = all_addr_zero & (col_stage[c].ccl_raddr == '0);
        end
    end

    // Address update lags col_valid by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            any_valid_d1 <= 1'b0;
            last_clause  <= 1'b0;
        end else begin
            any_valid_d1 <= any_valid;
            last_clause  <= any_valid_d1 && all_addr_zero;
        end
    end

    assign clause_flush  = start_d2 || last_clause;
    assign summation_ena = start_d3 || last_clause;

    a_last_sum: assert property (@(posedge clk) disable iff (!rst_n)
        (any_valid ##1 all_addr_zero) |=> (summation_ena && clause_flush))
        else $error("last clause without summation_ena and clause_flush");

endmodule

// ==== hw/distributor.sv ====
// Data distributor of the keyword-spotting accelerator
// Connects the feature fetch unit and the clause tracker to one lane per
// PE column
`timescale 1ns/1ps
`include "kws_settings.svh"

module distributor import kws_pkg::*; (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  decode_en,
    input  logic                                  block_ready,
    input  logic [$clog2(`KWS_BLOCK_DEPTH)-1:0]   block_raddr,
    input  col_stage_t                            col_stage [`KWS_N_PE_COL],
    input  logic [`KWS_N_FRAME-1:0]               feature_rdata,
    output logic                                  feature_ren,
    output logic [$clog2(2*`KWS_N_MEL)-1:0]       feature_rptr,
    output pe_lane_t                              pe_lane [`KWS_N_PE_COL],
    output logic                                  summation_ena
);

    logic [`KWS_N_FRAME-1:0]  row_lo;
    logic [`KWS_N_FRAME-1:0]  row_hi;
    logic [`KWS_N_PATCH-1:0]  pos_lo;
    logic [`KWS_N_PATCH-1:0]  pos_hi;
    logic                     row_ptr_zero;
    logic                     clause_flush;

    feature_fetch u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .decode_en     (decode_en),
        .block_ready   (block_ready),
        .feature_rdata (feature_rdata),
        .clause_flush  (clause_flush),
        .feature_ren   (feature_ren),
        .feature_rptr  (feature_rptr),
        .row_lo        (row_lo),
        .row_hi        (row_hi),
        .pos_lo        (pos_lo),
        .pos_hi        (pos_hi),
        .row_ptr_zero  (row_ptr_zero)
    );

    clause_tracker u_tracker (
        .clk           (clk),
        .rst_n         (rst_n),
        .decode_en     (decode_en),
        .block_ready   (block_ready),
        .row_ptr_zero  (row_ptr_zero),
        .block_raddr   (block_raddr),
        .col_stage     (col_stage),
        .clause_flush  (clause_flush),
        .summation_ena (summation_ena)
    );

    // One lane per PE column
    for (genvar c = 0; c < `KWS_N_PE_COL; c++) begin : g_lane
        pe_column_lane u_lane (
            .clk          (clk),
            .rst_n        (rst_n),
            .col_stage    (col_stage[c]),
            .row_lo       (row_lo),
            .row_hi       (row_hi),
            .pos_lo       (pos_lo),
            .pos_hi       (pos_hi),
            .clause_flush (clause_flush),
            .lane         (pe_lane[c])
        );
    end

endmodule

// ==== test/distributor_tb.sv ====
// Testbench for the keyword-spotting data distributor
// Models the feature bank, drives the block and column stages and checks
// reads, literal windows, position rows, flush flags and clause events
`timescale 1ns/1ps
`include "kws_settings.svh"

module distributor_tb import kws_pkg::*; ();

    localparam int CLK_PERIOD      = 20;
    localparam int TEST_CYCLES     = 200;
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;
    localparam logic [31:0] SEED   = 32'h1152_0f06;
    localparam logic [`KWS_N_PATCH-1:0] POS0_SHIFTED = `KWS_POS_INIT0 << 2;
    localparam logic [`KWS_N_PATCH-1:0] POS1_SHIFTED = `KWS_POS_INIT1 << 2;

    logic                                 clk;
    logic                                 rst_n;
    logic                                 decode_en;
    logic                                 block_ready;
    logic [$clog2(`KWS_BLOCK_DEPTH)-1:0]  block_raddr;
    col_stage_t                           col_stage [`KWS_N_PE_COL];
    logic [`KWS_N_FRAME-1:0]              feature_rdata = '0;
    logic                                 feature_ren;
    logic [$clog2(2*`KWS_N_MEL)-1:0]      feature_rptr;
    pe_lane_t                             pe_lane [`KWS_N_PE_COL];
    logic                                 summation_ena;

    logic                                 bank_req = 1'b0;
    logic [5:0]                           bank_addr = '0;
    logic [`KWS_N_FRAME-1:0]              bank_mask;
    logic                                 any_col_valid;
    logic                                 all_raddr_zero;
    logic                                 flags_all_ones;
    int                                   errors = 0;
    int                                   err_mark = 0;
    int                                   tests_run = 0;
    int                                   tests_failed = 0;

    distributor dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------------------
    // Feature bank model with data one cycle after the strobe
    // ------------------------------------------------------------------------

    function automatic logic [`KWS_N_FRAME-1:0] bank_row(input logic [5:0] addr);
        return {(`KWS_N_FRAME / 8){{2'b00, addr}}} ^ bank_mask;
    endfunction

    always @(posedge clk) begin
        bank_req  <= rst_n && feature_ren;
        bank_addr <= feature_rptr;
    end

    always @(negedge clk) begin
        if (bank_req) begin
            feature_rdata <= bank_row(bank_addr);
        end
    end

    // SEL_SHIFTk window is row bits k-1 up to k+56
    function automatic logic [`KWS_N_PATCH-1:0] expected_window(
        input logic [`KWS_N_FRAME-1:0] row, input int k);
        logic [`KWS_N_PATCH-1:0] w;
        for (int b = 0; b < `KWS_N_PATCH; b++) begin
            w[b] = row[k - 1 + b];
        end
        return w;
    endfunction

    // ------------------------------------------------------------------------
    // Timing rules
    // ------------------------------------------------------------------------

    always_comb begin
        any_col_valid  = 1'b0;
        all_raddr_zero = 1'b1;
        flags_all_ones = 1'b1;
        for (int c = 0; c < `KWS_N_PE_COL; c++) begin
            any_col_valid  = any_col_valid | col_stage[c].col_valid;
            all_raddr_zero = all_raddr_zero & (col_stage[c].ccl_raddr == '0);
            flags_all_ones = flags_all_ones & (&pe_lane[c].flush_flags);
        end
    end

    a_read_pair: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(feature_ren) |=> feature_ren && feature_rptr == 6'($past(feature_rptr) + 6'd1)
            ##1 !feature_ren)
        else begin
            $display("FAIL t=%0t: read pair was not two strobes at consecutive rows", $time);
            errors++;
        end

    a_clause_start: assert property (@(posedge clk) disable iff (!rst_n)
        decode_en && block_ready && feature_rptr == '0 && block_raddr != '0
            |-> ##3 summation_ena)
        else begin
            $display("FAIL t=%0t summation_ena expected 1 got 0", $time);
            errors++;
        end

    a_last_clause: assert property (@(posedge clk) disable iff (!rst_n)
        any_col_valid ##1 all_raddr_zero |=> summation_ena ##1 flags_all_ones)
        else begin
            $display("FAIL t=%0t: last clause did not raise summation_ena and refill flags",
                $time);
            errors++;
        end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    task automatic tick();
        @(negedge clk);
    endtask

    task automatic settle();
        #1;
    endtask

    task automatic start_test();
        err_mark = errors;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - err_mark);
        end else begin
            $display("%s: passed", name);
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("FAIL t=%0t %s expected %0h got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_literals(input logic [`KWS_N_PATCH-1:0] exp);
        for (int c = 0; c < `KWS_N_PE_COL; c++) begin
            check_value($sformatf("pe_lane[%0d].literal", c), pe_lane[c].literal, exp);
        end
    endtask

    task automatic check_flags(input logic [7:0] exp);
        for (int c = 0; c < `KWS_N_PE_COL; c++) begin
            check_value($sformatf("pe_lane[%0d].flush_flags", c), pe_lane[c].flush_flags, exp);
        end
    endtask

    // Lane control outputs follow the column stage directly
    task automatic check_controls(input logic ena, input logic [1:0] stage,
                                  input logic clause, input logic inv);
        for (int c = 0; c < `KWS_N_PE_COL; c++) begin
            check_value($sformatf("pe_lane[%0d].ena", c), pe_lane[c].ena, ena);
            check_value($sformatf("pe_lane[%0d].stage_code", c),
                pe_lane[c].stage_code, stage);
            check_value($sformatf("pe_lane[%0d].clause_sel", c),
                pe_lane[c].clause_sel, clause);
            check_value($sformatf("pe_lane[%0d].inv_en", c), pe_lane[c].inv_en, inv);
        end
    endtask

    // Same decoder entry on every column
    task automatic set_columns(input logic row_v, input logic spad, input logic col_v,
                               input col_sel_e sel, input logic [1:0] stage,
                               input logic clause, input logic [11:0] raddr);
        for (int c = 0; c < `KWS_N_PE_COL; c++) begin
            col_stage[c] = '0;
            col_stage[c].row_valid           = row_v;
            col_stage[c].row_spad_index      = spad;
            col_stage[c].col_valid           = col_v;
            col_stage[c].col_ready           = 1'b1;
            col_stage[c].clause_code.clause  = clause;
            col_stage[c].clause_code.col_sel = sel;
            col_stage[c].stage_code          = stage;
            col_stage[c].ccl_raddr           = raddr;
        end
    endtask

    // Invert bit of every column
    task automatic set_invert(input logic inv);
        for (int c = 0; c < `KWS_N_PE_COL; c++) begin
            col_stage[c].clause_code.invert = inv;
        end
    endtask

    // Single-cycle block handshake and both read strobes
    task automatic read_pair(input logic [10:0] raddr, input logic [5:0] ptr);
        logic [5:0] next_ptr;
        next_ptr    = ptr + 6'd1;
        tick();
        decode_en   = 1'b1;
        block_ready = 1'b1;
        block_raddr = raddr;
        settle();
        check_value("feature_ren", feature_ren, 1);
        check_value("feature_rptr", feature_rptr, ptr);
        tick();
        decode_en   = 1'b0;
        block_ready = 1'b0;
        settle();
        check_value("feature_ren", feature_ren, 1);
        check_value("feature_rptr", feature_rptr, next_ptr);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles before the tests finished",
            WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------

    initial begin
        logic [7:0] exp_flags;
        void'($urandom(SEED));
        bank_mask   = {$urandom, $urandom};
        clk         = 1'b0;
        rst_n       = 1'b0;
        decode_en   = 1'b0;
        block_ready = 1'b0;
        block_raddr = '0;
        set_columns(1'b0, 1'b0, 1'b0, SEL_POSITION, 2'd0, 1'b0, 12'd1);
        repeat (5) @(posedge clk);
        tick();
        rst_n = 1'b1;

        start_test();
        set_columns(1'b1, 1'b0, 1'b0, SEL_POSITION, 2'd0, 1'b0, 12'd1);
        settle();
        check_value("feature_ren", feature_ren, 0);
        check_value("summation_ena", summation_ena, 0);
        check_flags(8'hFF);
        check_literals(`KWS_POS_INIT0);
        tick();
        set_columns(1'b1, 1'b1, 1'b0, SEL_POSITION, 2'd0, 1'b0, 12'd1);
        settle();
        check_literals(`KWS_POS_INIT0);
        tick();
        set_columns(1'b0, 1'b1, 1'b0, SEL_POSITION, 2'd0, 1'b0, 12'd1);
        settle();
        check_literals(`KWS_POS_INIT1);
        finish_test("reset_state");

        start_test();
        read_pair(11'd0, 6'd0);
        tick();
        settle();
        check_value("feature_ren", feature_ren, 0);
        check_value("feature_rptr", feature_rptr, 2);
        finish_test("first_read");

        // Pair 0 now holds rows 0 and 1
        start_test();
        for (int s = 0; s < 2; s++) begin
            tick();
            set_columns(1'b1, 1'(s), 1'b0, SEL_POSITION, 2'd0, 1'b0, 12'd1);
            for (int k = 1; k < 8; k++) begin
                tick();
                set_columns(1'b0, 1'(s), 1'b0, col_sel_e'(k), 2'd0, 1'b0, 12'd1);
                settle();
                check_literals(expected_window(bank_row(6'(s)), k));
            end
        end
        finish_test("literal_windows");

        start_test();
        tick();
        set_columns(1'b1, 1'b0, 1'b0, SEL_POSITION, 2'd0, 1'b0, 12'd1);
        read_pair(11'd0, 6'd2);
        tick();
        settle();
        check_value("feature_ren", feature_ren, 0);
        check_value("feature_rptr", feature_rptr, 4);
        check_literals(`KWS_POS_INIT0);
        finish_test("second_read");

        // Swap and shift land two cycles after the handshake
        start_test();
        tick();
        set_columns(1'b1, 1'b1, 1'b0, SEL_POSITION, 2'd0, 1'b0, 12'd1);
        settle();
        check_literals(POS0_SHIFTED);
        tick();
        set_columns(1'b0, 1'b1, 1'b0, SEL_POSITION, 2'd0, 1'b0, 12'd1);
        settle();
        check_literals(POS1_SHIFTED);
        tick();
        set_columns(1'b0, 1'b1, 1'b0, SEL_SHIFT1, 2'd0, 1'b0, 12'd1);
        settle();
        check_literals(expected_window(bank_row(6'd3), 1));
        finish_test("position_shift");

        start_test();
        exp_flags = 8'hFF;
        for (int s = 0; s < 4; s++) begin
            for (int c = 0; c < 2; c++) begin
                tick();
                set_columns(1'b0, 1'b1, 1'b1, SEL_POSITION, 2'(s), 1'(c), 12'd1);
                set_invert(1'(s + c));
                settle();
                check_controls(1'b1, 2'(s), 1'(c), 1'(s + c));
                check_flags(exp_flags);
                exp_flags[s * 2 + c] = 1'b0;
            end
        end
        tick();
        set_columns(1'b0, 1'b1, 1'b0, SEL_POSITION, 2'd0, 1'b0, 12'd1);
        settle();
        check_controls(1'b0, 2'd0, 1'b0, 1'b0);
        check_flags(exp_flags);
        finish_test("flush_flags");

        // Walk the read pointer around to zero again
        start_test();
        for (int i = 0; i < `KWS_N_MEL - 2; i++) begin
            read_pair(11'd0, 6'(4 + 2 * i));
            tick();
        end
        settle();
        check_value("feature_rptr", feature_rptr, 0);
        check_flags(8'h00);
        finish_test("pointer_wrap");

        start_test();
        read_pair(11'd5, 6'd0);
        tick();
        settle();
        check_value("summation_ena", summation_ena, 0);
        check_flags(8'h00);
        tick();
        settle();
        check_value("summation_ena", summation_ena, 1);
        check_flags(8'hFF);
        check_literals(`KWS_POS_INIT1);
        tick();
        set_columns(1'b0, 1'b1, 1'b0, SEL_SHIFT2, 2'd0, 1'b0, 12'd1);
        settle();
        check_value("summation_ena", summation_ena, 0);
        check_literals(expected_window(bank_row(6'd1), 2));
        finish_test("clause_start");

        start_test();
        tick();
        set_columns(1'b0, 1'b1, 1'b1, SEL_POSITION, 2'd1, 1'b0, 12'd1);
        settle();
        check_value("summation_ena", summation_ena, 0);
        tick();
        set_columns(1'b0, 1'b1, 1'b0, SEL_POSITION, 2'd0, 1'b0, 12'd0);
        settle();
        check_value("summation_ena", summation_ena, 0);
        check_flags(8'hFB);
        tick();
        set_columns(1'b0, 1'b1, 1'b0, SEL_POSITION, 2'd0, 1'b0, 12'd1);
        settle();
        check_value("summation_ena", summation_ena, 1);
        tick();
        settle();
        check_value("summation_ena", summation_ena, 0);
        check_flags(8'hFF);
        finish_test("last_clause");

        $display("%0d tests run, %0d failed, %0d check errors",
            tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== distributor.f ====
+incdir+hw
hw/kws_pkg.sv
hw/feature_fetch.sv
hw/pe_column_lane.sv
hw/clause_tracker.sv
hw/distributor.sv
test/distributor_tb.sv

// ==== Makefile ====
# Verilator build and run for the data distributor testbench

TOP := distributor_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f distributor.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf obj_dir
